//--- dc304_mmu.f
+incdir+tests
logic/mmu_pkg.sv
logic/mmu_csr_axil.sv
logic/page_regs.sv
logic/xlate_ctrl.sv
logic/addr_relocate.sv
logic/mmu_top.sv
tests/mmu_tb.sv

//--- logic/addr_relocate.sv
/* Physical address adder and page length compare. rsp_pa is registered every
   cycle and so holds only while va_hold and the looked-up page stay unchanged. */
`timescale 1ns/10ps

module addr_relocate
(
   input  logic                      clk,
   input  logic [mmu_pkg::va_w-1:0]  va_hold,
   input  logic [15:0]               lk_par,
   input  logic [15:0]               lk_pdr,
   input  logic                      mmu_enable,
   input  logic                      map22,
   output logic [mmu_pkg::pa_w-1:0]  rsp_pa,
   output logic                      limit_err
);

logic [6:0]              block;         // 64-byte block within the page
logic [6:0]              plf;           // page length field
logic [mmu_pkg::pa_w-1:0] sum;
logic [mmu_pkg::pa_w-1:0] mapped;
logic [mmu_pkg::pa_w-1:0] unmapped;

assign block = va_hold[12:6];
assign plf   = lk_pdr[mmu_pkg::plf_msb:mmu_pkg::plf_lsb];

// upward pages end at the PLF, downward pages start there
assign limit_err = lk_pdr[mmu_pkg::pdr_exp_dn] ? (block < plf) : (block > plf);

assign sum = {lk_par, 6'd0} + {9'd0, va_hold[12:0]};  // PAR * 64 + offset

assign mapped = map22 ? sum
              : {{(mmu_pkg::pa_w - mmu_pkg::pa18_w){1'b0}}, sum[mmu_pkg::pa18_w-1:0]};
assign unmapped = {{(mmu_pkg::pa_w - mmu_pkg::va_w){1'b0}}, va_hold};

always_ff @(posedge clk)
begin
   rsp_pa <= mmu_enable ? mapped : unmapped;  // settles on the check to respond edge
end

endmodule

//--- logic/mmu_csr_axil.sv
/* AXI4-Lite register slave with SR0 and SR3. A read accepted in the same cycle
   holds off a write; unmapped offsets answer OKAY, read 0 and ignore writes. */
`timescale 1ns/10ps

module mmu_csr_axil
(
   input  logic                            clk,
   input  logic                            sr_rst,
   input  logic [mmu_pkg::reg_addr_w-1:0]  awaddr,
   input  logic                            awvalid,
   output logic                            awready,
   input  logic [15:0]                     wdata,
   input  logic [1:0]                      wstrb,
   input  logic                            wvalid,
   output logic                            wready,
   output logic [1:0]                      bresp,
   output logic                            bvalid,
   input  logic                            bready,
   input  logic [mmu_pkg::reg_addr_w-1:0]  araddr,
   input  logic                            arvalid,
   output logic                            arready,
   output logic [15:0]                     rdata,
   output logic [1:0]                      rresp,
   output logic                            rvalid,
   input  logic                            rready,
   input  logic [15:0]                     reg_rdata,
   input  logic                            abt_update,
   input  logic                            abt_nr,
   input  logic                            abt_ro,
   input  logic                            abt_le,
   input  logic                            abt_user,
   input  logic [2:0]                      abt_page,
   output logic                            reg_we_lo,
   output logic                            reg_we_hi,
   output logic                            reg_sel_par,
   output logic [3:0]                      reg_index,
   output logic [15:0]                     reg_wdata,
   output logic                            mmu_enable,
   output logic                            map22,
   output logic                            sr0_frozen
);

logic        live;                      // high from the first cycle after reset
logic        rd_take;
logic        wr_take;
logic [mmu_pkg::reg_addr_w-1:0] acc_addr;
logic        hit_kpdr, hit_kpar, hit_updr, hit_upar;
logic        hit_page, hit_sr0, hit_sr3;
logic [15:0] rd_value;
logic [15:0] sr0;
logic [15:0] sr3;

assign arready = live & ~rvalid;
assign rd_take = arvalid & arready;
assign wr_take = live & awvalid & wvalid & ~bvalid & ~rd_take;  // reads go first
assign awready = wr_take;
assign wready  = wr_take;
assign bresp   = 2'b00;                 // always OKAY
assign rresp   = 2'b00;

// one decoder serves both channels, they never take the same cycle
assign acc_addr = rd_take ? araddr : awaddr;
assign hit_kpdr = acc_addr[12:4] == mmu_pkg::off_kpdr[12:4];
assign hit_kpar = acc_addr[12:4] == mmu_pkg::off_kpar[12:4];
assign hit_updr = acc_addr[12:4] == mmu_pkg::off_updr[12:4];
assign hit_upar = acc_addr[12:4] == mmu_pkg::off_upar[12:4];
assign hit_page = hit_kpdr | hit_kpar | hit_updr | hit_upar;
assign hit_sr0  = acc_addr[12:1] == mmu_pkg::off_sr0[12:1];
assign hit_sr3  = acc_addr[12:1] == mmu_pkg::off_sr3[12:1];

assign reg_sel_par = hit_kpar | hit_upar;
assign reg_index   = {hit_updr | hit_upar, acc_addr[3:1]};  // user set is upper half
assign reg_wdata   = wdata;
assign reg_we_lo   = wr_take & hit_page & wstrb[0];
assign reg_we_hi   = wr_take & hit_page & wstrb[1];

assign rd_value = hit_page ? reg_rdata :
                  hit_sr0  ? sr0 :
                  hit_sr3  ? sr3 : 16'd0;

assign mmu_enable = sr0[mmu_pkg::sr0_enable];
assign map22      = sr3[mmu_pkg::sr3_map22];
assign sr0_frozen = |sr0[15:13];        // any abort flag pending

always_ff @(posedge clk)
begin
   if (sr_rst)
   begin
      live   <= 1'b0;
      bvalid <= 1'b0;
      rvalid <= 1'b0;
   end
   else
   begin
      live <= 1'b1;
      if (wr_take)
         bvalid <= 1'b1;
      else if (bready)
         bvalid <= 1'b0;
      if (rd_take)
         rvalid <= 1'b1;
      else if (rready)
         rvalid <= 1'b0;
   end
end

always_ff @(posedge clk)
begin
   if (rd_take)
      rdata <= rd_value;
end

always_ff @(posedge clk)
begin
   if (sr_rst)
   begin
      sr0 <= 16'd0;
      sr3 <= 16'd0;
   end
   else
   begin
      if (abt_update & ~sr0_frozen)
      begin
         sr0[15:13] <= {abt_nr, abt_le, abt_ro};  // nr, le, ro from the top
         sr0[6:5]   <= {abt_user, abt_user};
         sr0[3:1]   <= abt_page;
      end
      if (wr_take & hit_sr0)            // software write wins over capture
      begin
         if (wstrb[1])
            sr0[15:13] <= wdata[15:13];
         if (wstrb[0])
            sr0[mmu_pkg::sr0_enable] <= wdata[mmu_pkg::sr0_enable];
      end
      if (wr_take & hit_sr3 & wstrb[0])
         sr3[mmu_pkg::sr3_map22] <= wdata[mmu_pkg::sr3_map22];
   end
end

endmodule

//--- logic/mmu_pkg.sv
/* DC304 MMU constants. Offsets are the low 13 bits of the octal I/O page address;
   PDR bits outside pdr_read_mask always read as zero. */

package mmu_pkg;

   // address widths
   localparam int va_w       = 16;  // virtual address
   localparam int pa_w       = 22;  // physical address, 22-bit mode
   localparam int pa18_w     = 18;  // physical address, 18-bit mode
   localparam int reg_addr_w = 13;  // register port byte offset

   // page register sets, eight words each at byte stride 2
   localparam logic [reg_addr_w-1:0] off_kpdr = 13'o12300;  // kernel descriptors
   localparam logic [reg_addr_w-1:0] off_kpar = 13'o12340;  // kernel page addresses
   localparam logic [reg_addr_w-1:0] off_updr = 13'o17600;  // user descriptors
   localparam logic [reg_addr_w-1:0] off_upar = 13'o17640;  // user page addresses

   // status registers
   localparam logic [reg_addr_w-1:0] off_sr0 = 13'o17572;
   localparam logic [reg_addr_w-1:0] off_sr3 = 13'o12516;

   // page descriptor layout
   localparam logic [15:0] pdr_read_mask = 16'o077516;  // bits that read back
   localparam int pdr_resident = 1;  // page present
   localparam int pdr_wr_en    = 2;  // write allowed
   localparam int pdr_exp_dn   = 3;  // page grows downward
   localparam int pdr_w_bit    = 6;  // page written since last PDR load
   localparam int plf_lsb      = 8;  // page length field
   localparam int plf_msb      = 14;

   // status enables
   localparam int sr0_enable = 0;  // relocation on
   localparam int sr3_map22  = 4;  // 22-bit physical addressing

endpackage

//--- logic/mmu_top.sv
/* DC304 memory management top. One translation is in flight at a time and
   register writes during a translation's lookup cycle may or may not be seen. */
`timescale 1ns/10ps

module mmu_top
(
   input  logic                            clk,
   input  logic                            sr_rst,
   // register port
   input  logic [mmu_pkg::reg_addr_w-1:0]  awaddr,
   input  logic                            awvalid,
   output logic                            awready,
   input  logic [15:0]                     wdata,
   input  logic [1:0]                      wstrb,
   input  logic                            wvalid,
   output logic                            wready,
   output logic [1:0]                      bresp,
   output logic                            bvalid,
   input  logic                            bready,
   input  logic [mmu_pkg::reg_addr_w-1:0]  araddr,
   input  logic                            arvalid,
   output logic                            arready,
   output logic [15:0]                     rdata,
   output logic [1:0]                      rresp,
   output logic                            rvalid,
   input  logic                            rready,
   // translation port
   input  logic [mmu_pkg::va_w-1:0]        req_va,
   input  logic                            req_write,
   input  logic                            req_user,
   input  logic                            req_valid,
   output logic                            req_ready,
   output logic [mmu_pkg::pa_w-1:0]        rsp_pa,
   output logic                            rsp_abort_nr,
   output logic                            rsp_abort_ro,
   output logic                            rsp_abort_le,
   output logic                            rsp_valid,
   input  logic                            rsp_ready
);

logic        reg_we_lo;                 // register file byte strobes
logic        reg_we_hi;
logic        reg_sel_par;               // PAR rather than PDR
logic [3:0]  reg_index;
logic [15:0] reg_wdata;
logic [15:0] reg_rdata;
logic        mmu_enable;                // SR0 bit 0
logic        map22;                     // SR3 bit 4
logic [3:0]  lk_index;                  // translation lookup
logic [15:0] lk_par;
logic [15:0] lk_pdr;
logic        w_set;
logic [mmu_pkg::va_w-1:0] va_hold;
logic        limit_err;
logic        abt_update;                // SR0 abort capture
logic        abt_nr;
logic        abt_ro;
logic        abt_le;
logic        abt_user;
logic [2:0]  abt_page;

mmu_csr_axil csr_i
(
   .clk         (clk),
   .sr_rst      (sr_rst),
   .awaddr      (awaddr),
   .awvalid     (awvalid),
   .awready     (awready),
   .wdata       (wdata),
   .wstrb       (wstrb),
   .wvalid      (wvalid),
   .wready      (wready),
   .bresp       (bresp),
   .bvalid      (bvalid),
   .bready      (bready),
   .araddr      (araddr),
   .arvalid     (arvalid),
   .arready     (arready),
   .rdata       (rdata),
   .rresp       (rresp),
   .rvalid      (rvalid),
   .rready      (rready),
   .reg_rdata   (reg_rdata),
   .abt_update  (abt_update),
   .abt_nr      (abt_nr),
   .abt_ro      (abt_ro),
   .abt_le      (abt_le),
   .abt_user    (abt_user),
   .abt_page    (abt_page),
   .reg_we_lo   (reg_we_lo),
   .reg_we_hi   (reg_we_hi),
   .reg_sel_par (reg_sel_par),
   .reg_index   (reg_index),
   .reg_wdata   (reg_wdata),
   .mmu_enable  (mmu_enable),
   .map22       (map22),
   .sr0_frozen  ()                      // status only, gating is internal
);

page_regs regs_i
(
   .clk         (clk),
   .sr_rst      (sr_rst),
   .reg_we_lo   (reg_we_lo),
   .reg_we_hi   (reg_we_hi),
   .reg_sel_par (reg_sel_par),
   .reg_index   (reg_index),
   .reg_wdata   (reg_wdata),
   .lk_index    (lk_index),
   .w_set       (w_set),
   .reg_rdata   (reg_rdata),
   .lk_par      (lk_par),
   .lk_pdr      (lk_pdr)
);

xlate_ctrl ctrl_i
(
   .clk          (clk),
   .sr_rst       (sr_rst),
   .req_va       (req_va),
   .req_write    (req_write),
   .req_user     (req_user),
   .req_valid    (req_valid),
   .rsp_ready    (rsp_ready),
   .mmu_enable   (mmu_enable),
   .lk_pdr       (lk_pdr),
   .limit_err    (limit_err),
   .req_ready    (req_ready),
   .rsp_valid    (rsp_valid),
   .rsp_abort_nr (rsp_abort_nr),
   .rsp_abort_ro (rsp_abort_ro),
   .rsp_abort_le (rsp_abort_le),
   .lk_index     (lk_index),
   .w_set        (w_set),
   .va_hold      (va_hold),
   .abt_update   (abt_update),
   .abt_nr       (abt_nr),
   .abt_ro       (abt_ro),
   .abt_le       (abt_le),
   .abt_user     (abt_user),
   .abt_page     (abt_page)
);

addr_relocate reloc_i
(
   .clk        (clk),
   .va_hold    (va_hold),
   .lk_par     (lk_par),
   .lk_pdr     (lk_pdr),
   .mmu_enable (mmu_enable),
   .map22      (map22),
   .rsp_pa     (rsp_pa),
   .limit_err  (limit_err)
);

endmodule

//--- logic/page_regs.sv
/* Kernel and user PAR/PDR file, kernel at index 0-7 and user at 8-15.
   Lookup data appears one cycle after lk_index; a PDR write clears its W bit. */
`timescale 1ns/10ps

module page_regs
(
   input  logic        clk,
   input  logic        sr_rst,
   input  logic        reg_we_lo,
   input  logic        reg_we_hi,
   input  logic        reg_sel_par,
   input  logic [3:0]  reg_index,
   input  logic [15:0] reg_wdata,
   input  logic [3:0]  lk_index,
   input  logic        w_set,
   output logic [15:0] reg_rdata,
   output logic [15:0] lk_par,
   output logic [15:0] lk_pdr
);

// W bit reads back but is never loaded from the bus
localparam logic [15:0] pdr_wr_mask =
   mmu_pkg::pdr_read_mask & ~(16'd1 << mmu_pkg::pdr_w_bit);

logic [15:0] par [16];
logic [15:0] pdr [16];
logic [15:0] pdr_wdata;

assign pdr_wdata = reg_wdata & pdr_wr_mask;

always_ff @(posedge clk)
begin
   if (sr_rst)
   begin
      for (int i = 0; i < 16; i++)
      begin
         par[i] <= 16'd0;
         pdr[i] <= 16'd0;
      end
   end
   else
   begin
      if (w_set)
         pdr[lk_index][mmu_pkg::pdr_w_bit] <= 1'b1;  // page dirtied
      if (reg_sel_par)
      begin
         if (reg_we_lo)
            par[reg_index][7:0] <= reg_wdata[7:0];
         if (reg_we_hi)
            par[reg_index][15:8] <= reg_wdata[15:8];
      end
      else if (reg_we_lo | reg_we_hi)
      begin
         if (reg_we_lo)
            pdr[reg_index][7:0] <= pdr_wdata[7:0];
         if (reg_we_hi)
            pdr[reg_index][15:8] <= pdr_wdata[15:8];
         pdr[reg_index][mmu_pkg::pdr_w_bit] <= 1'b0;  // reload clears dirty flag
      end
   end
end

assign reg_rdata = reg_sel_par ? par[reg_index] : (pdr[reg_index] & mmu_pkg::pdr_read_mask);

always_ff @(posedge clk)
begin
   lk_par <= par[lk_index];
   lk_pdr <= pdr[lk_index] & mmu_pkg::pdr_read_mask;
end

endmodule

//--- logic/xlate_ctrl.sv
/* Translation sequencer, idle/lookup/check/respond. Response follows two edges
   after acceptance; a new request may be taken on the response handshake. */
`timescale 1ns/10ps

module xlate_ctrl
(
   input  logic                      clk,
   input  logic                      sr_rst,
   input  logic [mmu_pkg::va_w-1:0]  req_va,
   input  logic                      req_write,
   input  logic                      req_user,
   input  logic                      req_valid,
   input  logic                      rsp_ready,
   input  logic                      mmu_enable,
   input  logic [15:0]               lk_pdr,
   input  logic                      limit_err,
   output logic                      req_ready,
   output logic                      rsp_valid,
   output logic                      rsp_abort_nr,
   output logic                      rsp_abort_ro,
   output logic                      rsp_abort_le,
   output logic [3:0]                lk_index,
   output logic                      w_set,
   output logic [mmu_pkg::va_w-1:0]  va_hold,
   output logic                      abt_update,
   output logic                      abt_nr,
   output logic                      abt_ro,
   output logic                      abt_le,
   output logic                      abt_user,
   output logic [2:0]                abt_page
);

localparam logic [1:0] st_idle    = 2'd0;
localparam logic [1:0] st_lookup  = 2'd1;  // page registers being read
localparam logic [1:0] st_check   = 2'd2;  // descriptor valid, aborts decided
localparam logic [1:0] st_respond = 2'd3;

logic [1:0] state;
logic       write_hold;
logic       user_hold;
logic       accept;
logic       in_check;
logic       any_abt;

assign req_ready = (state == st_idle) | ((state == st_respond) & rsp_ready);
assign accept    = req_valid & req_ready;
assign rsp_valid = state == st_respond;
assign in_check  = state == st_check;

assign lk_index = {user_hold, va_hold[15:13]};  // mode bit, then page

// abort checks, none while relocation is off
assign abt_nr = mmu_enable & ~lk_pdr[mmu_pkg::pdr_resident];
assign abt_ro = mmu_enable & lk_pdr[mmu_pkg::pdr_resident] & write_hold
              & ~lk_pdr[mmu_pkg::pdr_wr_en];
assign abt_le = mmu_enable & limit_err;
assign any_abt = abt_nr | abt_ro | abt_le;

assign abt_update = in_check & any_abt;
assign abt_user   = user_hold;
assign abt_page   = va_hold[15:13];
assign w_set      = in_check & mmu_enable & write_hold & ~any_abt;

always_ff @(posedge clk)
begin
   if (sr_rst)
      state <= st_idle;
   else
   begin
      case (state)
         st_idle:    if (accept) state <= st_lookup;
         st_lookup:  state <= st_check;
         st_check:   state <= st_respond;
         st_respond: if (rsp_ready) state <= accept ? st_lookup : st_idle;
         default:    state <= st_idle;
      endcase
   end
end

always_ff @(posedge clk)
begin
   if (accept)
   begin
      va_hold    <= req_va;
      write_hold <= req_write;
      user_hold  <= req_user;
   end
   if (in_check)
   begin
      rsp_abort_nr <= abt_nr;
      rsp_abort_ro <= abt_ro;
      rsp_abort_le <= abt_le;
   end
end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Builds and runs the DC304 MMU testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module mmu_tb -f dc304_mmu.f \
   -o mmu_sim
if [ $? -ne 0 ]; then
   echo "build failed"
   exit 1
fi

./obj_dir/mmu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "Errors found" "$LOG"; then
   exit 1
fi
exit 0

//--- tests/mmu_model.svh
/* Reference model of the page registers, SR0/SR3 and the translation rule.
   Included inside the testbench module; calls must follow DUT order. */
`ifndef MMU_MODEL_SVH
`define MMU_MODEL_SVH

logic [15:0] m_par [16];
logic [15:0] m_pdr [16];
logic [15:0] m_sr0 = 16'd0;
logic [15:0] m_sr3 = 16'd0;

// kind 0 unmapped, 1 PAR, 2 PDR, 3 SR0, 4 SR3
function automatic int decode_offset(input logic [12:0] a, output int idx);
   idx = 0;
   if (a >= mmu_pkg::off_kpdr && a <= mmu_pkg::off_kpdr + 15)
   begin
      idx = (a - mmu_pkg::off_kpdr) >> 1;
      return 2;
   end
   if (a >= mmu_pkg::off_kpar && a <= mmu_pkg::off_kpar + 15)
   begin
      idx = (a - mmu_pkg::off_kpar) >> 1;
      return 1;
   end
   if (a >= mmu_pkg::off_updr && a <= mmu_pkg::off_updr + 15)
   begin
      idx = 8 + ((a - mmu_pkg::off_updr) >> 1);
      return 2;
   end
   if (a >= mmu_pkg::off_upar && a <= mmu_pkg::off_upar + 15)
   begin
      idx = 8 + ((a - mmu_pkg::off_upar) >> 1);
      return 1;
   end
   if ((a >> 1) == (mmu_pkg::off_sr0 >> 1))
      return 3;
   if ((a >> 1) == (mmu_pkg::off_sr3 >> 1))
      return 4;
   return 0;
endfunction

function automatic void store_register(input logic [12:0] a, input logic [15:0] d,
                                       input logic [1:0] strb);
   int idx;
   int kind;
   logic [15:0] lanes;
   kind  = decode_offset(a, idx);
   lanes = {{8{strb[1]}}, {8{strb[0]}}};
   case (kind)
      1: m_par[idx] = (m_par[idx] & ~lanes) | (d & lanes);
      2: if (strb != 2'b00)
         begin
            m_pdr[idx] = (m_pdr[idx] & ~lanes) | (d & mmu_pkg::pdr_read_mask & lanes);
            m_pdr[idx][mmu_pkg::pdr_w_bit] = 1'b0;  // reload leaves page clean
         end
      3:
      begin
         if (strb[1]) m_sr0[15:13] = d[15:13];
         if (strb[0]) m_sr0[0] = d[0];
      end
      4: if (strb[0]) m_sr3[4] = d[4];
      default: ;
   endcase
endfunction

function automatic logic [15:0] fetch_register(input logic [12:0] a);
   int idx;
   case (decode_offset(a, idx))
      1: return m_par[idx];
      2: return m_pdr[idx] & mmu_pkg::pdr_read_mask;
      3: return m_sr0;
      4: return m_sr3;
      default: return 16'd0;
   endcase
endfunction

function automatic void expected_translation(input logic [15:0] va, input logic wr,
   input logic user, output logic [21:0] pa, output logic nr, output logic ro, output logic le);
   int idx;
   logic [15:0] pdr;
   logic [6:0] plf;
   idx = {user, va[15:13]};
   pdr = m_pdr[idx];
   plf = pdr[14:8];
   pa  = ({6'd0, m_par[idx]} << 6) + {9'd0, va[12:0]};
   if (!m_sr3[4])
      pa[21:18] = 4'd0;                 // 18-bit mode
   nr = ~pdr[1];
   ro = pdr[1] & wr & ~pdr[2];
   le = pdr[3] ? (va[12:6] < plf) : (va[12:6] > plf);
   if (!m_sr0[0])
   begin
      pa = {6'd0, va};
      nr = 0;
      ro = 0;
      le = 0;
   end
   else if (nr | ro | le)
   begin
      if (m_sr0[15:13] == 3'd0)          // capture only while not frozen
      begin
         m_sr0[15:13] = {nr, le, ro};
         m_sr0[6:5]   = {user, user};
         m_sr0[3:1]   = va[15:13];
      end
   end
   else if (wr)
      m_pdr[idx][6] = 1'b1;
endfunction

`endif

//--- tests/mmu_tb.sv
/* Random testbench for mmu_top against the included model. Register writes and
   translations are never overlapped; outputs are sampled on the falling edge. */
`timescale 1ns/10ps

module mmu_tb;

`include "mmu_model.svh"

localparam int n_reg = 40;
localparam int n_xl = 32;
localparam int op_cycles = 10;          // worst case of one handshake with stalls
localparam int total_ops = 2 * n_reg + 5 * n_xl + 89;
localparam int cycle_limit = 4 * op_cycles * total_ops;

logic clk = 0;
logic sr_rst = 1;
logic [12:0] awaddr = 0;
logic [12:0] araddr = 0;
logic awvalid = 0;
logic wvalid = 0;
logic bready = 0;
logic arvalid = 0;
logic rready = 0;
logic [15:0] wdata = 0;
logic [1:0] wstrb = 0;
logic awready;
logic wready;
logic bvalid;
logic arready;
logic rvalid;
logic [1:0] bresp;
logic [1:0] rresp;
logic [15:0] rdata;
logic [15:0] req_va = 0;
logic req_write = 0;
logic req_user = 0;
logic req_valid = 0;
logic rsp_ready = 0;
logic req_ready;
logic rsp_valid;
logic rsp_abort_nr;
logic rsp_abort_ro;
logic rsp_abort_le;
logic [21:0] rsp_pa;
int cycles = 0;
int checks = 0;
int errors = 0;
int test_errors = 0;
int test_checks = 0;
string test_name = "";

mmu_top dut_i (.*);

initial
begin
   forever #20 clk = ~clk;
end

always @(posedge clk)
begin
   cycles++;
   if (cycles >= cycle_limit)
   begin
      $display("timeout: run did not complete within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
   end
end

task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
   checks++;
   assert (exp === act) else
   begin
      $display("Fail %s %s expected %h actual %h", test_name, name, exp, act);
      errors++;
   end
endtask

task automatic end_test();
   $display("test %s: %0d checks, %0d errors", test_name, checks - test_checks,
            errors - test_errors);
   test_checks = checks;
   test_errors = errors;
endtask

function automatic logic [12:0] page_offset(input logic par, input logic [3:0] idx);
   logic [12:0] base;
   base = idx[3] ? (par ? mmu_pkg::off_upar : mmu_pkg::off_updr)
                 : (par ? mmu_pkg::off_kpar : mmu_pkg::off_kpdr);
   return base + {idx[2:0], 1'b0};
endfunction

task automatic axi_write(input logic [12:0] a, input logic [15:0] d, input logic [1:0] s);
   @(negedge clk);
   awaddr  = a;
   wdata   = d;
   wstrb   = s;
   awvalid = 1;
   wvalid  = 1;
   #1;
   while (!(awready && wready))
   begin
      @(negedge clk);
      #1;
   end
   @(posedge clk);
   @(negedge clk);
   awvalid = 0;
   wvalid  = 0;
   while (!bvalid) @(negedge clk);
   repeat ($urandom % 4)
   begin
      @(negedge clk);
      compare("bvalid held", 1, bvalid);
   end
   compare("bresp", 0, bresp);
   bready = 1;
   @(posedge clk);
   @(negedge clk);
   bready = 0;
   store_register(a, d, s);
endtask

task automatic axi_read(input string name, input logic [12:0] a, output logic [15:0] d);
   @(negedge clk);
   araddr  = a;
   arvalid = 1;
   #1;
   while (!arready)
   begin
      @(negedge clk);
      #1;
   end
   @(posedge clk);
   @(negedge clk);
   arvalid = 0;
   while (!rvalid) @(negedge clk);
   d = rdata;
   repeat ($urandom % 4)
   begin
      @(negedge clk);
      compare("rdata held", {14'd0, 2'b10, d}, {14'd0, rvalid, arready, rdata});  // no new read
   end
   compare(name, fetch_register(a), d);
   compare("rresp", 0, rresp);
   rready = 1;
   @(posedge clk);
   @(negedge clk);
   rready = 0;
endtask

task automatic translate(input string name, input logic [15:0] va, input logic wr,
                         input logic user);
   logic [21:0] e_pa;
   logic e_nr;
   logic e_ro;
   logic e_le;
   logic [24:0] got;
   int lat;
   expected_translation(va, wr, user, e_pa, e_nr, e_ro, e_le);
   @(negedge clk);
   req_va    = va;
   req_write = wr;
   req_user  = user;
   req_valid = 1;
   #1;
   while (!req_ready)
   begin
      @(negedge clk);
      #1;
   end
   @(posedge clk);
   lat = 0;
   do
   begin
      @(negedge clk);
      req_valid = 0;
      lat++;
   end while (!rsp_valid);
   compare({name, " latency"}, 3, lat);  // falling edges up to valid, two clocks
   got = {rsp_abort_nr, rsp_abort_ro, rsp_abort_le, rsp_pa};
   compare(name, {7'd0, e_nr, e_ro, e_le, e_pa}, {7'd0, got});
   repeat ($urandom % 4)
   begin
      @(negedge clk);
      compare({name, " held"}, {7'd1, got}, {6'd0, rsp_valid, rsp_abort_nr, rsp_abort_ro,
                                             rsp_abort_le, rsp_pa});
   end
   rsp_ready = 1;
   @(posedge clk);
   @(negedge clk);
   rsp_ready = 0;
endtask

initial
begin
   logic [12:0] a;
   logic [15:0] d;
   int idx;
   int kind;
   void'($urandom(32'h717f));
   for (int i = 0; i < 16; i++)
   begin
      m_par[i] = 0;
      m_pdr[i] = 0;
   end
   repeat (4) @(posedge clk);
   @(negedge clk);
   sr_rst = 0;
   test_name = "reset values";
   compare("outputs after reset", 7'b1000000,
           {req_ready, awready, wready, arready, bvalid, rvalid, rsp_valid});
   end_test();

   test_name = "register round trip";
   for (int i = 0; i < n_reg; i++)
   begin
      kind = $urandom % 7;
      if (kind < 4)
         a = page_offset(kind[0], 4'($urandom));
      else if (kind == 4)
         a = mmu_pkg::off_sr0;
      else if (kind == 5)
         a = mmu_pkg::off_sr3;
      else
         do a = 13'($urandom) & 13'h1ffe; while (decode_offset(a, idx) != 0);
      axi_write(a, 16'($urandom), 2'($urandom));
      axi_read("register readback", a, d);
   end
   end_test();

   test_name = "mapping disabled";
   axi_write(mmu_pkg::off_sr0, 16'd0, 2'b11);
   for (int i = 0; i < n_xl; i++)
      translate("unmapped translation", 16'($urandom), 1'($urandom), 1'($urandom));
   end_test();

   test_name = "mapped 18 and 22 bit";
   for (int i = 0; i < 16; i++)
   begin
      axi_write(page_offset(1, 4'(i)), 16'($urandom), 2'b11);
      axi_write(page_offset(0, 4'(i)), 16'h7f06, 2'b11);  // resident, writable, full length
   end
   axi_write(mmu_pkg::off_sr0, 16'd1, 2'b11);
   axi_write(mmu_pkg::off_sr3, 16'd0, 2'b11);
   for (int i = 0; i < n_xl; i++)
   begin
      if (i == n_xl / 2)
         axi_write(mmu_pkg::off_sr3, 16'h0010, 2'b11);
      translate("mapped translation", 16'($urandom), 1'($urandom), 1'($urandom));
   end
   end_test();

   test_name = "aborts and sr0 freeze";
   for (int i = 0; i < 16; i++)
   begin
      axi_write(page_offset(1, 4'(i)), 16'($urandom), 2'b11);
      axi_write(page_offset(0, 4'(i)), 16'($urandom) & 16'h7f0e, 2'b11);
   end
   axi_write(mmu_pkg::off_sr0, 16'd1, 2'b11);
   for (int i = 0; i < n_xl; i++)
   begin
      translate("abort translation", 16'($urandom), 1'($urandom), 1'($urandom));
      axi_read("sr0 after translation", mmu_pkg::off_sr0, d);
      if (i % 5 == 4)
         axi_write(mmu_pkg::off_sr0, 16'd1, 2'b11);  // clear aborts, keep enable
   end
   end_test();

   test_name = "w bit";
   axi_write(mmu_pkg::off_sr0, 16'd1, 2'b11);
   for (int i = 0; i < 3; i++)
   begin
      idx = $urandom % 16;
      axi_write(page_offset(0, 4'(idx)), 16'h7f06, 2'b11);
      translate("dirtying write", {idx[2:0], 13'($urandom)}, 1, idx[3]);
      axi_read("pdr after write", page_offset(0, 4'(idx)), d);
      compare("w bit set", 1, d[6]);
      axi_write(page_offset(0, 4'(idx)), 16'h7f06, 2'b01);
      axi_read("pdr after reload", page_offset(0, 4'(idx)), d);
      compare("w bit cleared", 0, d[6]);
   end
   end_test();

   $display("total: %0d checks, %0d errors, %0d cycles", checks, errors, cycles);
   if (errors == 0)
      $display("No errors");
   else
      $display("Errors found");
   $finish;
end

endmodule
